/* Bender.yml */
package:
  name: timer0

sources:
  - verilog/timerPkg.sv
  - verilog/busPkg.sv
  - verilog/timerRegs.sv
  - verilog/timerCounter.sv
  - verilog/compareOutput.sv
  - verilog/irqFlags.sv
  - verilog/timer0.sv
  - target: test
    files:
      - tests/timer0Tb.sv

/* sim.f */
verilog/timerPkg.sv
verilog/busPkg.sv
verilog/timerRegs.sv
verilog/timerCounter.sv
verilog/compareOutput.sv
verilog/irqFlags.sv
verilog/timer0.sv
tests/timer0Tb.sv

/* tests/timer0Tb.sv */
`timescale 1ns/1ps

module timer0Tb;
	import timerPkg::*;
	import busPkg::*;

	typedef enum logic [2:0] {opIoWr, opIoRd, opRamWr, opRamRd, opRun, opAck} op_t;

	typedef struct packed {
		op_t         op;
		logic [11:0] addr;
		logic [7:0]  data;     // Write data, or cycle count for a run
		logic        en;
		count_t      expVal;   // Read data for reads other than TIFR
	} step_t;

	localparam logic [11:0] aTccrA = 12'h024;
	localparam logic [11:0] aTccrB = 12'h025;
	localparam logic [11:0] aTcnt  = 12'h026;
	localparam logic [11:0] aOcrA  = 12'h027;
	localparam logic [11:0] aOcrB  = 12'h028;
	localparam logic [11:0] aTifr  = 12'h015;
	localparam logic [11:0] aTimsk = 12'h06E;

	logic cp2 = 1'b0;
	logic ireset;
	logic cntEn;
	busReq_t bus;
	logic [5:0] irqAckAddr;
	logic irqAck;
	count_t dbusOut;
	logic outEn;
	logic [2:0] csn;
	logic ocA;
	logic ocB;
	logic ocAEn;
	logic ocBEn;
	flags_t irq;

	step_t steps[$];
	int countErrs = 0;
	int flagErrs = 0;
	int pinErrs = 0;
	int limitCycles = 0;
	logic [23:0] lfsr = 24'd81745;

	// Reference model state
	count_t mCnt;
	count_t mOcr[2];
	count_t mBuf[2];
	logic [2:0] mWgm;
	logic [1:0] mCom[2];
	logic [2:0] mCsn;
	flags_t mFlags;
	flags_t mMask;
	logic mOc[2];

	timer0 UUT (
		.cp2(cp2),
		.ireset(ireset),
		.cntEn(cntEn),
		.bus(bus),
		.dbusOut(dbusOut),
		.outEn(outEn),
		.irqAckAddr(irqAckAddr),
		.irqAck(irqAck),
		.csn(csn),
		.ocA(ocA),
		.ocB(ocB),
		.ocAEn(ocAEn),
		.ocBEn(ocBEn),
		.irq(irq)
	);

	always #5 cp2 = ~cp2;

	// x^24 + x^23 + x^22 + x^17 + 1
	function automatic logic [23:0] lfsrNext(input logic [23:0] s);
		return {s[22:0], s[23] ^ s[22] ^ s[21] ^ s[16]};
	endfunction

	function automatic count_t randByte();
		count_t v;
		v = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsrNext(lfsr);
			v = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	// Pin driver on for any connected mode, toggle only where the mode allows it
	function automatic logic pinEnable(input logic [1:0] com, input logic [2:0] wgm,
		input logic pwmToggle);
		if (com == 2'd1) begin
			return (wgm == 3'd0) || (wgm == 3'd2) || (pwmToggle && wgm == 3'd7);
		end
		return com != 2'd0;
	endfunction

	function automatic busReq_t makeReq(input op_t op, input logic [11:0] addr,
		input logic [7:0] data);
		busReq_t r;
		r = '0;
		r.busEn = 1'b1;
		r.wdata = data;
		r.ioAddr = addr[5:0];
		r.ramAddr = addr;
		r.ioWe = (op == opIoWr);
		r.ioRe = (op == opIoRd);
		r.ramWe = (op == opRamWr);
		r.ramRe = (op == opRamRd);
		return r;
	endfunction

	task automatic addStep(input op_t op, input logic [11:0] addr, input logic [7:0] data,
		input logic en, input count_t expVal);
		step_t s;
		s = '{op, addr, data, en, expVal};
		steps.push_back(s);
	endtask

	task automatic driveCycle(input busReq_t r, input logic en, input logic ack,
		input logic [5:0] vec);
		@(posedge cp2);
		bus <= r;
		cntEn <= en;
		irqAck <= ack;
		irqAckAddr <= vec;
	endtask

	task automatic checkCount(input count_t got, input count_t exp, input string what);
		if (got !== exp) begin
			countErrs++;
			$display("Error %0t ns: %s gave 0x%02h, expected 0x%02h", $time, what, got, exp);
		end
	endtask

	task automatic checkFlags(input flags_t got, input flags_t exp, input string what);
		if (got !== exp) begin
			flagErrs++;
			$display("Error %0t ns: %s gave %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic checkPin(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			pinErrs++;
			$display("Error %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic checkSel(input logic [2:0] got, input logic [2:0] exp, input string what);
		if (got !== exp) begin
			pinErrs++;
			$display("Error %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// Cycle model, sees the inputs as they stand before each edge
	always @(posedge cp2 or negedge ireset) begin : model
		logic ioWr;
		logic pwmBuf;
		logic match;
		count_t top;
		flags_t setF;
		flags_t clrF;
		if (!ireset) begin
			mCnt = '0;
			mOcr = '{default: '0};
			mBuf = '{default: '0};
			mWgm = '0;
			mCom = '{default: '0};
			mCsn = '0;
			mFlags = '0;
			mMask = '0;
			mOc = '{default: 1'b0};
		end else begin
			ioWr = bus.busEn && bus.ioWe;
			pwmBuf = (mWgm[1:0] == 2'b11);
			top = (mWgm == 3'd2 || mWgm == 3'd7) ? mOcr[0] : 8'hFF;
			setF = '0;
			if (cntEn) begin
				setF.ovf = mWgm[2] ? (mWgm == 3'd7 && mCnt == top) : (mCnt == 8'hFF);
				setF.cmpA = (mCnt == mOcr[0]);
				setF.cmpB = (mCnt == mOcr[1]);
			end
			clrF = (ioWr && bus.ioAddr == aTifr[5:0]) ? flags_t'(bus.wdata[2:0]) : flags_t'(0);
			clrF.ovf |= irqAck && (irqAckAddr == 6'h10);
			clrF.cmpA |= irqAck && (irqAckAddr == 6'h0E);
			clrF.cmpB |= irqAck && (irqAckAddr == 6'h0F);
			mFlags = (mFlags & ~clrF) | setF;
			for (int i = 0; i < 2; i++) begin
				match = (mCnt == mOcr[i]);
				if (mCom[i] == 2'd0) begin
					mOc[i] = 1'b0;
				end else if (cntEn && (mWgm == 3'd0 || mWgm == 3'd2) && match) begin
					mOc[i] = (mCom[i] == 2'd1) ? ~mOc[i] : mCom[i][0];
				end else if (cntEn && pwmBuf && mCom[i] == 2'd1) begin
					mOc[i] = (mWgm == 3'd7 && i == 0) ? (mOc[i] ^ match) : 1'b0;   // Only A
				end else if (cntEn && pwmBuf) begin
					mOc[i] = match ? mCom[i][0] : ((mCnt == 8'h00) ? ~mCom[i][0] : mOc[i]);
				end
				if (pwmBuf && cntEn && mCnt == 8'h00) begin
					mOcr[i] = mBuf[i];   // New duty from bottom
				end
				if (ioWr && bus.ioAddr == ((i == 0) ? aOcrA[5:0] : aOcrB[5:0])) begin
					mBuf[i] = bus.wdata;
					if (!pwmBuf) begin
						mOcr[i] = bus.wdata;
					end
				end
			end
			if (ioWr && bus.ioAddr == aTcnt[5:0]) begin
				mCnt = bus.wdata;
			end else if (cntEn && (mWgm == 3'd0 || mWgm == 3'd3)) begin
				mCnt = mCnt + 8'd1;
			end else if (cntEn && (mWgm == 3'd2 || mWgm == 3'd7)) begin
				mCnt = (mCnt == top) ? 8'h00 : mCnt + 8'd1;
			end
			if (ioWr && bus.ioAddr == aTccrA[5:0]) begin
				mCom[0] = bus.wdata[7:6];
				mCom[1] = bus.wdata[5:4];
				mWgm[1:0] = bus.wdata[1:0];
			end
			if (ioWr && bus.ioAddr == aTccrB[5:0]) begin
				mWgm[2] = bus.wdata[3];
				mCsn = bus.wdata[2:0];
			end
			if (bus.busEn && bus.ramWe && bus.ramAddr == aTimsk) begin
				mMask = flags_t'(bus.wdata[2:0]);
			end
		end
	end

	initial begin : watchdog
		wait (limitCycles > 0);
		#(limitCycles * 10);
		$display("Timeout: the test table did not finish within %0d cycles", limitCycles);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		step_t st;
		count_t r;
		logic known;
		int total;
		ireset = 1'b0;
		cntEn = 1'b0;
		bus = '0;
		irqAckAddr = '0;
		irqAck = 1'b0;

		// Register readback
		addStep(opIoWr, aTccrA, 8'hF7, 0, 0);
		addStep(opIoRd, aTccrA, 0, 0, 8'hF3);
		addStep(opIoWr, aTccrB, 8'hFF, 0, 0);
		addStep(opIoRd, aTccrB, 0, 0, 8'h0F);
		addStep(opIoWr, aTccrB, 8'h00, 0, 0);
		addStep(opIoWr, aTccrA, 8'h00, 0, 0);
		addStep(opIoRd, 12'h030, 0, 0, 8'h00);   // Unmapped
		addStep(opRamWr, aTimsk, 8'hFF, 0, 0);
		addStep(opRamRd, aTimsk, 0, 0, 8'h07);
		addStep(opRamWr, aTimsk, 8'h00, 0, 0);
		// Normal mode, one run across 0xFF and one without
		addStep(opIoWr, aTcnt, 8'hF0, 0, 0);
		addStep(opRun, 0, 8'h20, 1, 0);
		addStep(opIoRd, aTcnt, 0, 0, 8'h10);
		addStep(opIoRd, aTifr, 0, 0, 0);
		addStep(opIoWr, aTifr, 8'h07, 0, 0);
		addStep(opIoWr, aTcnt, 8'h20, 0, 0);
		addStep(opRun, 0, 8'h40, 1, 0);
		addStep(opIoRd, aTcnt, 0, 0, 8'h60);
		addStep(opIoRd, aTifr, 0, 0, 0);
		// CTC with toggle on A and B
		r = randByte() | 8'h10;
		addStep(opIoWr, aOcrA, r, 0, 0);
		addStep(opIoWr, aTccrA, 8'h52, 0, 0);
		addStep(opIoWr, aTifr, 8'h07, 0, 0);
		addStep(opIoWr, aTcnt, 8'h00, 0, 0);
		addStep(opRun, 0, 8'd250, 1, 0);
		addStep(opIoRd, aTcnt, 0, 0, count_t'(250 % (int'(r) + 1)));
		addStep(opIoRd, aTifr, 0, 0, 0);
		// Fast PWM, compare write in mid period, B inverting
		addStep(opIoWr, aOcrA, 8'h40, 0, 0);
		addStep(opIoWr, aTccrA, 8'hB3, 0, 0);
		addStep(opIoWr, aTcnt, 8'h00, 0, 0);
		addStep(opRun, 0, 8'h80, 1, 0);
		addStep(opIoWr, aOcrA, 8'hA0, 0, 0);
		addStep(opIoRd, aOcrA, 0, 0, 8'hA0);
		addStep(opRun, 0, 8'h30, 1, 0);
		addStep(opRun, 0, 8'h50, 1, 0);
		addStep(opRun, 0, 8'h50, 1, 0);
		addStep(opRun, 0, 8'h60, 1, 0);
		addStep(opIoRd, aTcnt, 0, 0, 8'hB0);
		// Flags, mask and acknowledge
		addStep(opIoRd, aTifr, 0, 0, 0);
		addStep(opRamWr, aTimsk, 8'h07, 0, 0);
		addStep(opAck, 12'h010, 0, 0, 0);         // Overflow vector
		addStep(opIoRd, aTifr, 0, 0, 0);
		addStep(opIoWr, aTifr, 8'h04, 0, 0);
		addStep(opIoRd, aTifr, 0, 0, 0);
		addStep(opRamRd, aTimsk, 0, 0, 8'h07);

		total = 0;
		foreach (steps[i]) begin
			total += (steps[i].op == opRun) ? int'(steps[i].data) : 1;
		end
		limitCycles = total + 100;

		repeat (10) @(posedge cp2);
		ireset <= 1'b1;
		foreach (steps[i]) begin
			st = steps[i];
			if (st.op == opRun) begin
				repeat (st.data) driveCycle('0, st.en, 1'b0, 6'h00);
			end else if (st.op == opAck) begin
				driveCycle('0, 1'b0, 1'b1, st.addr[5:0]);
			end else begin
				driveCycle(makeReq(st.op, st.addr, st.data), st.en, 1'b0, 6'h00);
			end
			@(negedge cp2);
			if (st.op == opIoRd || st.op == opRamRd) begin
				known = (st.op == opRamRd) ? (st.addr == aTimsk) :
					(st.addr >= aTccrA && st.addr <= aOcrB) || (st.addr == aTifr);
				checkPin(outEn, known, $sformatf("outEn at 0x%03h", st.addr));
				if (st.op == opIoRd && st.addr == aTifr) begin
					checkFlags(flags_t'(dbusOut[2:0]), mFlags, "TIFR read");
				end else begin
					checkCount(dbusOut, st.expVal, $sformatf("read of 0x%03h", st.addr));
				end
			end
			checkFlags(irq, mFlags & mMask, "irq");
			checkPin(ocA, mOc[0], "ocA");
			checkPin(ocB, mOc[1], "ocB");
			checkPin(ocAEn, pinEnable(mCom[0], mWgm, 1'b1), "ocAEn");
			checkPin(ocBEn, pinEnable(mCom[1], mWgm, 1'b0), "ocBEn");
			checkSel(csn, mCsn, "csn");
		end
		driveCycle('0, 1'b0, 1'b0, 6'h00);

		total = countErrs + flagErrs + pinErrs;
		$display("Checks done: count errors %0d, flag errors %0d, pin errors %0d",
			countErrs, flagErrs, pinErrs);
		if (total == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* verilog/busPkg.sv */
package busPkg;

	localparam int ioAddrW  = 6;    // I/O space
	localparam int ramAddrW = 12;   // Data space, RAM-mapped registers
	localparam int dataW    = 8;

	// One CPU access, all fields sampled in the same cycle
	typedef struct packed {
		logic [ioAddrW-1:0]  ioAddr;
		logic [ramAddrW-1:0] ramAddr;
		logic [dataW-1:0]    wdata;
		logic                ioWe;
		logic                ioRe;
		logic                ramWe;
		logic                ramRe;
		logic                busEn;   // Core clock enable
	} busReq_t;

endpackage

/* verilog/compareOutput.sv */
`timescale 1ns/1ps

module compareOutput #(
	parameter bit pwmToggle = 1'b0
) (
	input  logic               cp2,
	input  logic               ireset,
	input  timerPkg::cntStat_t stat,
	input  timerPkg::wgm_t     wgm,
	input  timerPkg::com_t     com,
	input  logic               match,
	output logic               oc,
	output logic               ocEn
);
	import timerPkg::*;

	logic nonPwm;
	logic fastPwm;
	logic toggleOk;

	assign nonPwm = (wgm == wgmNormal) || (wgm == wgmCtc);
	assign fastPwm = (wgm == wgmFastPwm) || (wgm == wgmFastPwmOcr);
	// Toggle in PWM only where TOP is OCRA and the channel allows it
	assign toggleOk = nonPwm || (pwmToggle && (wgm == wgmFastPwmOcr));

	assign ocEn = (com == comClear) || (com == comSet) ||
		((com == comToggle) && toggleOk);

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			oc <= 1'b0;
		end else if (com == comOff) begin
			oc <= 1'b0;                        // Disconnected
		end else if (stat.tick) begin
			if (nonPwm) begin
				if (match) begin
					case (com)
						comToggle: oc <= ~oc;
						comClear:  oc <= 1'b0;
						comSet:    oc <= 1'b1;
						default:   oc <= 1'b0;
					endcase
				end
			end else if (fastPwm) begin
				case (com)
					comToggle: begin
						if (!toggleOk) begin
							oc <= 1'b0;
						end else if (match) begin
							oc <= ~oc;
						end
					end
					comClear: begin                 // Non-inverting
						if (match) begin
							oc <= 1'b0;
						end else if (stat.atBottom) begin
							oc <= 1'b1;
						end
					end
					comSet: begin                   // Inverting
						if (match) begin
							oc <= 1'b1;
						end else if (stat.atBottom) begin
							oc <= 1'b0;
						end
					end
					default: oc <= 1'b0;
				endcase
			end
		end
	end

endmodule

/* verilog/irqFlags.sv */
`timescale 1ns/1ps

module irqFlags #(
	parameter logic [5:0] vecOvf,
	parameter logic [5:0] vecCmpA,
	parameter logic [5:0] vecCmpB
) (
	input  logic               cp2,
	input  logic               ireset,
	input  timerPkg::cntStat_t stat,
	input  timerPkg::wgm_t     wgm,
	input  timerPkg::flags_t   tifrClr,
	input  timerPkg::flags_t   mask,
	input  logic [5:0]         irqAckAddr,
	input  logic               irqAck,
	output timerPkg::flags_t   tifr,
	output timerPkg::flags_t   irq
);
	import timerPkg::*;

	flags_t setFl;
	flags_t ackFl;

	always_comb begin
		// Overflow at MAX below mode 4, at TOP in mode 7
		if (wgm[2]) begin
			setFl.ovf = stat.tick && (wgm == wgmFastPwmOcr) && stat.atTop;
		end else begin
			setFl.ovf = stat.tick && stat.atMax;
		end
		setFl.cmpA = stat.tick && stat.matchA;
		setFl.cmpB = stat.tick && stat.matchB;
		ackFl.ovf = irqAck && (irqAckAddr == vecOvf);   // Vector taken
		ackFl.cmpA = irqAck && (irqAckAddr == vecCmpA);
		ackFl.cmpB = irqAck && (irqAckAddr == vecCmpB);
	end

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			tifr <= flags_t'(3'b000);
		end else begin
			tifr <= (tifr & ~(ackFl | tifrClr)) | setFl;   // Set beats clear
		end
	end

	assign irq = tifr & mask;

	// Acknowledged flag is clear after the edge unless set again
	ackClearsFlag: assert property (@(posedge cp2) disable iff (!ireset)
		(|(ackFl & ~setFl)) |=> ((tifr & $past(ackFl & ~setFl)) == 3'b000));

endmodule

/* verilog/timer0.sv */
`timescale 1ns/1ps

module timer0 #(
	parameter logic [busPkg::ioAddrW-1:0]  addrTccrA = 6'h24,
	parameter logic [busPkg::ioAddrW-1:0]  addrTccrB = 6'h25,
	parameter logic [busPkg::ioAddrW-1:0]  addrTcnt  = 6'h26,
	parameter logic [busPkg::ioAddrW-1:0]  addrOcrA  = 6'h27,
	parameter logic [busPkg::ioAddrW-1:0]  addrOcrB  = 6'h28,
	parameter logic [busPkg::ioAddrW-1:0]  addrTifr  = 6'h15,
	parameter logic [busPkg::ramAddrW-1:0] addrTimsk = 12'h06E,
	parameter logic [5:0]                  vecOvf    = 6'h10,
	parameter logic [5:0]                  vecCmpA   = 6'h0E,
	parameter logic [5:0]                  vecCmpB   = 6'h0F
) (
	input  logic             cp2,
	input  logic             ireset,
	input  logic             cntEn,      // Prescaled count enable
	input  busPkg::busReq_t  bus,
	output timerPkg::count_t dbusOut,
	output logic             outEn,
	input  logic [5:0]       irqAckAddr,
	input  logic             irqAck,
	output logic [2:0]       csn,
	output logic             ocA,
	output logic             ocB,
	output logic             ocAEn,
	output logic             ocBEn,
	output timerPkg::flags_t irq
);
	import timerPkg::*;

	timerCtrl_t ctrl;
	cntStat_t stat;
	flags_t tifr;
	flags_t tifrClr;
	flags_t mask;
	logic tcntWr;

	timerRegs #(
		.addrTccrA(addrTccrA),
		.addrTccrB(addrTccrB),
		.addrTcnt(addrTcnt),
		.addrOcrA(addrOcrA),
		.addrOcrB(addrOcrB),
		.addrTifr(addrTifr),
		.addrTimsk(addrTimsk)
	) regs (
		.cp2(cp2),
		.ireset(ireset),
		.bus(bus),
		.stat(stat),
		.tifr(tifr),
		.ctrl(ctrl),
		.tcntWr(tcntWr),
		.tifrClr(tifrClr),
		.mask(mask),
		.csn(csn),
		.dbusOut(dbusOut),
		.outEn(outEn)
	);

	timerCounter counter (
		.cp2(cp2),
		.ireset(ireset),
		.cntEn(cntEn),
		.tcntWr(tcntWr),
		.wdata(bus.wdata),
		.ctrl(ctrl),
		.stat(stat)
	);

	compareOutput #(.pwmToggle(1'b1)) cmpA (
		.cp2(cp2),
		.ireset(ireset),
		.stat(stat),
		.wgm(ctrl.wgm),
		.com(ctrl.comA),
		.match(stat.matchA),
		.oc(ocA),
		.ocEn(ocAEn)
	);

	compareOutput #(.pwmToggle(1'b0)) cmpB (
		.cp2(cp2),
		.ireset(ireset),
		.stat(stat),
		.wgm(ctrl.wgm),
		.com(ctrl.comB),
		.match(stat.matchB),
		.oc(ocB),
		.ocEn(ocBEn)
	);

	irqFlags #(
		.vecOvf(vecOvf),
		.vecCmpA(vecCmpA),
		.vecCmpB(vecCmpB)
	) flags (
		.cp2(cp2),
		.ireset(ireset),
		.stat(stat),
		.wgm(ctrl.wgm),
		.tifrClr(tifrClr),
		.mask(mask),
		.irqAckAddr(irqAckAddr),
		.irqAck(irqAck),
		.tifr(tifr),
		.irq(irq)
	);

endmodule

/* verilog/timerCounter.sv */
`timescale 1ns/1ps

module timerCounter (
	input  logic                 cp2,
	input  logic                 ireset,
	input  logic                 cntEn,
	input  logic                 tcntWr,
	input  timerPkg::count_t     wdata,
	input  timerPkg::timerCtrl_t ctrl,
	output timerPkg::cntStat_t   stat
);
	import timerPkg::*;

	count_t cnt;
	count_t top;
	logic clrAtTop;

	// CTC and mode 7 wrap at OCRA
	assign clrAtTop = (ctrl.wgm == wgmCtc) || (ctrl.wgm == wgmFastPwmOcr);
	assign top = clrAtTop ? ctrl.ocrA : 8'hFF;

	// All comparisons of the counter value live here
	assign stat = '{
		value:    cnt,
		tick:     cntEn,
		atTop:    (cnt == top),
		atBottom: (cnt == 8'h00),
		atMax:    (cnt == 8'hFF),
		matchA:   (cnt == ctrl.ocrA),
		matchB:   (cnt == ctrl.ocrB)
	};

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			cnt <= '0;
		end else if (tcntWr) begin
			cnt <= wdata;                  // CPU write wins over counting
		end else if (cntEn) begin
			case (ctrl.wgm)
				wgmNormal, wgmFastPwm: begin
					cnt <= cnt + 8'd1;         // Natural wrap at 0xFF
				end
				wgmCtc, wgmFastPwmOcr: begin
					if (stat.atTop) begin
						cnt <= '0;
					end else begin
						cnt <= cnt + 8'd1;
					end
				end
				default: begin
					cnt <= cnt;                // Unused modes hold
				end
			endcase
		end
	end

	// Counter started at or below TOP stays there after a counting edge
	ctrStaysBelowTop: assert property (@(posedge cp2) disable iff (!ireset)
		(cntEn && !tcntWr && clrAtTop && (top != 8'h00) && (cnt <= top))
		|=> (cnt <= $past(top)));

endmodule

/* verilog/timerPkg.sv */
package timerPkg;

	typedef logic [7:0] count_t;   // Counter and compare width

	// Waveform generation mode, {TCCRB[3], TCCRA[1:0]}
	typedef enum logic [2:0] {
		wgmNormal     = 3'd0,   // TOP = 0xFF
		wgmCtc        = 3'd2,   // TOP = OCRA
		wgmFastPwm    = 3'd3,   // TOP = 0xFF
		wgmFastPwmOcr = 3'd7    // TOP = OCRA
	} wgm_t;

	typedef enum logic [1:0] {
		comOff    = 2'd0,
		comToggle = 2'd1,
		comClear  = 2'd2,
		comSet    = 2'd3
	} com_t;

	typedef struct packed {
		wgm_t   wgm;
		com_t   comA;
		com_t   comB;
		count_t ocrA;   // Active copy
		count_t ocrB;   // Active copy
	} timerCtrl_t;

	// Status of the present counter value
	typedef struct packed {
		count_t value;
		logic   tick;       // Counting edge this cycle
		logic   atTop;
		logic   atBottom;
		logic   atMax;
		logic   matchA;
		logic   matchB;
	} cntStat_t;

	// Bit order follows TIFR and TIMSK
	typedef struct packed {
		logic cmpB;   // Bit 2
		logic cmpA;   // Bit 1
		logic ovf;    // Bit 0
	} flags_t;

endpackage

/* verilog/timerRegs.sv */
`timescale 1ns/1ps

module timerRegs #(
	parameter logic [busPkg::ioAddrW-1:0]  addrTccrA,
	parameter logic [busPkg::ioAddrW-1:0]  addrTccrB,
	parameter logic [busPkg::ioAddrW-1:0]  addrTcnt,
	parameter logic [busPkg::ioAddrW-1:0]  addrOcrA,
	parameter logic [busPkg::ioAddrW-1:0]  addrOcrB,
	parameter logic [busPkg::ioAddrW-1:0]  addrTifr,
	parameter logic [busPkg::ramAddrW-1:0] addrTimsk
) (
	input  logic                cp2,
	input  logic                ireset,
	input  busPkg::busReq_t     bus,
	input  timerPkg::cntStat_t  stat,
	input  timerPkg::flags_t    tifr,
	output timerPkg::timerCtrl_t ctrl,
	output logic                tcntWr,
	output timerPkg::flags_t    tifrClr,
	output timerPkg::flags_t    mask,
	output logic [2:0]          csn,
	output timerPkg::count_t    dbusOut,
	output logic                outEn
);
	import timerPkg::*;

	logic ioWr;
	logic ramWr;
	logic wrTccrA;
	logic wrTccrB;
	logic wrTifr;
	logic wrTimsk;
	logic [1:0] wrOcr;          // Index 0 is channel A
	com_t comA;
	com_t comB;
	logic [2:0] wgmBits;        // Raw, may hold unused modes
	count_t [1:0] ocrBuf;
	count_t [1:0] ocrAct;
	logic buffered;
	logic reload;

	assign ioWr = bus.busEn && bus.ioWe;
	assign ramWr = bus.busEn && bus.ramWe;
	assign wrTccrA = ioWr && (bus.ioAddr == addrTccrA);
	assign wrTccrB = ioWr && (bus.ioAddr == addrTccrB);
	assign tcntWr = ioWr && (bus.ioAddr == addrTcnt);
	assign wrTifr = ioWr && (bus.ioAddr == addrTifr);
	assign wrOcr[0] = ioWr && (bus.ioAddr == addrOcrA);
	assign wrOcr[1] = ioWr && (bus.ioAddr == addrOcrB);
	assign wrTimsk = ramWr && (bus.ramAddr == addrTimsk);

	// Write one to clear
	assign tifrClr = wrTifr ? flags_t'(bus.wdata[2:0]) : flags_t'(3'b000);

	assign buffered = (wgmBits[1:0] == 2'b11);   // Both fast PWM modes
	assign reload = buffered && stat.tick && stat.atBottom;

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			comA <= comOff;
			comB <= comOff;
			wgmBits <= 3'b000;
			csn <= 3'b000;
			mask <= flags_t'(3'b000);
		end else begin
			if (wrTccrA) begin
				comA <= com_t'(bus.wdata[7:6]);
				comB <= com_t'(bus.wdata[5:4]);
				wgmBits[1:0] <= bus.wdata[1:0];
			end
			if (wrTccrB) begin
				wgmBits[2] <= bus.wdata[3];
				csn <= bus.wdata[2:0];        // Prescaler select
			end
			if (wrTimsk) begin
				mask <= flags_t'(bus.wdata[2:0]);
			end
		end
	end

	// Compare buffers and active copies for both channels
	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			ocrBuf <= '0;
			ocrAct <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (wrOcr[i]) begin
					ocrBuf[i] <= bus.wdata;
				end
				if (wrOcr[i] && !buffered) begin
					ocrAct[i] <= bus.wdata;   // Immediate update
				end else if (reload) begin
					ocrAct[i] <= ocrBuf[i];   // Takes effect from bottom
				end
			end
		end
	end

	assign ctrl = '{
		wgm:  wgm_t'(wgmBits),
		comA: comA,
		comB: comB,
		ocrA: ocrAct[0],
		ocrB: ocrAct[1]
	};

	always_comb begin
		dbusOut = '0;
		outEn = 1'b0;
		if (bus.ioRe) begin
			outEn = 1'b1;
			case (bus.ioAddr)
				addrTccrA: dbusOut = {comA, comB, 2'b00, wgmBits[1:0]};
				addrTccrB: dbusOut = {4'b0000, wgmBits[2], csn};
				addrTcnt:  dbusOut = stat.value;
				addrOcrA:  dbusOut = ocrBuf[0];   // Buffer, not active copy
				addrOcrB:  dbusOut = ocrBuf[1];
				addrTifr:  dbusOut = {5'b00000, tifr};
				default:   outEn = 1'b0;
			endcase
		end else if (bus.ramRe && (bus.ramAddr == addrTimsk)) begin
			outEn = 1'b1;
			dbusOut = {5'b00000, mask};
		end
	end

	// Active compare copies hold in fast PWM until a counting edge at bottom
	activeHeldInPwm: assert property (@(posedge cp2) disable iff (!ireset)
		(buffered && !reload) |=> (ocrAct == $past(ocrAct)));

endmodule
